// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       := peInputTopTb
RTL_TOP   := peInputTop
FILELIST  := peInputTop.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation gave no result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: logic/ackCredit.sv
`timescale 1ns/1ps
`include "peInput_defs.svh"

module ackCredit (
    input  logic clk,
    input  logic rst,
    input  logic ack,
    input  logic consume,
    output logic creditAvail
);

    // Acks not yet spent on a timestep 0 packet
    peInputPkg::creditCount_t credits;

    logic atMax;
    logic atZero;

    assign atMax = (credits == peInputPkg::creditCount_t'(`CREDIT_MAX));
    assign atZero = (credits == '0);

    // Level seen by the issue control
    assign creditAvail = !atZero;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else begin
            case ({ack, consume})
                // Ack at the limit is lost
                2'b10: begin
                    if (!atMax) begin
                        credits <= credits + 1'b1;
                    end
                end
                // Never below zero
                2'b01: begin
                    if (!atZero) begin
                        credits <= credits - 1'b1;
                    end
                end
                // Ack and consume together cancel
                default: credits <= credits;
            endcase
        end
    end

    // Control may only spend a credit it has seen
    consumeHasCredit: assert property (@(posedge clk) disable iff (rst)
        consume |-> creditAvail)
        else $error("ackCredit consume without credit");

endmodule

// File: logic/fifoBus.sv
`timescale 1ns/1ps

interface fifoBus;

    // Enqueue strobe and its packet
    logic push;
    peInputPkg::instWord_t pushData;

    // Dequeue strobe from the issue control
    logic pop;

    // Oldest stored packet, valid while not empty
    peInputPkg::instWord_t headData;
    logic empty;
    peInputPkg::fifoCount_t count;

    // Network side
    modport writer (
        output push,
        output pushData
    );

    // Issue control side
    modport reader (
        output pop,
        input  headData,
        input  empty,
        input  count
    );

    // The buffer itself
    modport storage (
        input  push,
        input  pushData,
        input  pop,
        output headData,
        output empty,
        output count
    );

endinterface

// File: logic/instFifo.sv
`timescale 1ns/1ps
`include "peInput_defs.svh"

module instFifo (
    input  logic clk,
    input  logic rst,
    fifoBus.storage bus,
    output logic overflow
);

    // Packet storage
    peInputPkg::instWord_t mem [`FIFO_DEPTH];

    // Pointers wrap on their own with a power of two depth
    logic [`FIFO_PTR_W-1:0] wrPtr;
    logic [`FIFO_PTR_W-1:0] rdPtr;

    // Number of stored packets
    peInputPkg::fifoCount_t occupancy;

    logic full;
    logic doPush;
    logic doPop;

    assign full = (occupancy == peInputPkg::fifoCount_t'(`FIFO_DEPTH));

    // Push to a full buffer is dropped
    assign doPush = bus.push && !full;
    assign doPop = bus.pop && (occupancy != '0);

    // Head is read straight from the array
    assign bus.headData = mem[rdPtr];
    assign bus.empty = (occupancy == '0);
    assign bus.count = occupancy;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
            overflow <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({doPush, doPop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            // Sticky until reset
            if (bus.push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= bus.pushData;
        end
    end

    // Issue control must never pop an empty buffer
    popNotEmpty: assert property (@(posedge clk) disable iff (rst)
        bus.pop |-> !bus.empty)
        else $error("instFifo pop while empty");

endmodule

// File: logic/outStage.sv
`timescale 1ns/1ps

module outStage (
    input  logic clk,
    input  logic rst,
    input  logic issue,
    input  peInputPkg::instWord_t issueData,
    input  peInputPkg::peNode_t node,
    output logic outValid,
    output peInputPkg::outWord_t outData,
    output peInputPkg::statCount_t filterCount,
    output peInputPkg::statCount_t ifmapCount
);

    // Bit 0 tells filter from ifmap
    logic isFilter;

    assign isFilter = issueData[0];

    // One cycle pulse per issued packet
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= issue;
        end
    end

    // Packet tagged with this PE's node number
    always_ff @(posedge clk) begin
        if (issue) begin
            outData <= {issueData, node};
        end
    end

    // Emitted packets by kind
    always_ff @(posedge clk) begin
        if (rst) begin
            filterCount <= '0;
            ifmapCount <= '0;
        end else if (issue) begin
            if (isFilter) begin
                filterCount <= filterCount + 1'b1;
            end else begin
                ifmapCount <= ifmapCount + 1'b1;
            end
        end
    end

endmodule

// File: logic/peInputCtrl.sv
`timescale 1ns/1ps

module peInputCtrl (
    input  logic clk,
    input  logic rst,
    fifoBus.reader fifo,
    input  logic creditAvail,
    output logic consume,
    output logic issue,
    output peInputPkg::instWord_t issueData
);

    peInputPkg::ctrlState_t state;

    // Timestep 0 ifmap packet at the head
    logic needAck;

    // Head is allowed out now
    logic headGo;

    // Decision taken this cycle
    logic launch;

    // Low two bits both zero means ifmap with timestep 0
    assign needAck = (fifo.headData[1:0] == 2'b00);
    assign headGo = !fifo.empty && (!needAck || creditAvail);

    // No decision while the head is still settling
    assign launch = headGo && (state != peInputPkg::ISSUE);

    // Registered strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            fifo.pop <= 1'b0;
            issue <= 1'b0;
            consume <= 1'b0;
        end else begin
            fifo.pop <= launch;
            issue <= launch;
            // Gated head spends one credit as it leaves
            consume <= launch && needAck;
        end
    end

    // Packet captured with the decision
    always_ff @(posedge clk) begin
        if (launch) begin
            issueData <= fifo.headData;
        end
    end

    // State machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= peInputPkg::IDLE;
        end else begin
            case (state)
                peInputPkg::IDLE: begin
                    if (launch) begin
                        state <= peInputPkg::ISSUE;
                    end else if (!fifo.empty) begin
                        // Gated head blocks everything behind it
                        state <= peInputPkg::WAIT_ACK;
                    end
                end
                peInputPkg::WAIT_ACK: begin
                    if (launch) begin
                        state <= peInputPkg::ISSUE;
                    end
                end
                // One cycle for the pop to land
                peInputPkg::ISSUE: begin
                    state <= peInputPkg::IDLE;
                end
                default: begin
                    state <= peInputPkg::IDLE;
                end
            endcase
        end
    end

    // Issued packet stays at the FIFO head until its pop lands
    issueWithPop: assert property (@(posedge clk) disable iff (rst)
        issue |-> fifo.pop && (issueData == fifo.headData))
        else $error("peInputCtrl issue without matching pop");

    // Waiting only makes sense on a stored gated head
    waitOnGated: assert property (@(posedge clk) disable iff (rst)
        (state == peInputPkg::WAIT_ACK) |-> (fifo.count != '0) && needAck)
        else $error("peInputCtrl waiting without a gated head");

endmodule

// File: logic/peInputPkg.sv
`include "peInput_defs.svh"

package peInputPkg;

    // One instruction packet as it arrives from the network
    typedef logic [`INST_W-1:0] instWord_t;

    // PE node number appended to every emitted word
    typedef logic [`NODE_W-1:0] peNode_t;

    // Packet above the node number
    typedef logic [`INST_W+`NODE_W-1:0] outWord_t;

    // FIFO occupancy, needs one bit above the pointer
    typedef logic [`FIFO_PTR_W:0] fifoCount_t;

    // Acks not yet matched to a packet
    typedef logic [3:0] creditCount_t;

    // Emitted packet counters
    typedef logic [`STAT_W-1:0] statCount_t;

    // Issue control machine
    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_ACK} ctrlState_t;

endpackage

// File: logic/peInputTop.sv
`timescale 1ns/1ps

module peInputTop #(
    parameter peInputPkg::peNode_t PE_NODE = 4'h0
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  peInputPkg::instWord_t inData,
    input  logic ack,
    output logic outValid,
    output peInputPkg::outWord_t outData,
    output peInputPkg::statCount_t filterCount,
    output peInputPkg::statCount_t ifmapCount,
    output logic overflow
);

    // Credit link
    logic consume;
    logic creditAvail;

    // Control to output stage
    logic issue;
    peInputPkg::instWord_t issueData;

    fifoBus fifoIf ();

    // Network input feeds the FIFO directly
    assign fifoIf.push = inValid;
    assign fifoIf.pushData = inData;

    instFifo i_instFifo (
        .clk      (clk),
        .rst      (rst),
        .bus      (fifoIf.storage),
        .overflow (overflow)
    );

    ackCredit i_ackCredit (
        .clk         (clk),
        .rst         (rst),
        .ack         (ack),
        .consume     (consume),
        .creditAvail (creditAvail)
    );

    peInputCtrl i_peInputCtrl (
        .clk         (clk),
        .rst         (rst),
        .fifo        (fifoIf.reader),
        .creditAvail (creditAvail),
        .consume     (consume),
        .issue       (issue),
        .issueData   (issueData)
    );

    // Node number fixed per PE instance
    outStage i_outStage (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issueData   (issueData),
        .node        (PE_NODE),
        .outValid    (outValid),
        .outData     (outData),
        .filterCount (filterCount),
        .ifmapCount  (ifmapCount)
    );

endmodule

// File: logic/peInput_defs.svh
`ifndef PEINPUT_DEFS_SVH
`define PEINPUT_DEFS_SVH

// Instruction FIFO geometry
`define FIFO_DEPTH 16
`define FIFO_PTR_W 4

// Stored acks saturate here
`define CREDIT_MAX 15

// Width of the emitted packet counters
`define STAT_W 16

// Packet and node widths
`define INST_W 14
`define NODE_W 4

`endif

// File: peInputTop.f
+incdir+logic
logic/peInputPkg.sv
logic/fifoBus.sv
logic/instFifo.sv
logic/ackCredit.sv
logic/peInputCtrl.sv
logic/outStage.sv
logic/peInputTop.sv
tests/peInputTopTb.sv

// File: tests/peInputTopTb.sv
`timescale 1ns/1ps

module peInputTopTb;

    // Path from the project root
    localparam string STIM_FILE = "tests/peInputTop_tests.txt";

    logic clk;
    logic rst;
    logic inValid;
    peInputPkg::instWord_t inData;
    logic ack;
    logic outValid;
    peInputPkg::outWord_t outData;
    peInputPkg::statCount_t filterCount;
    peInputPkg::statCount_t ifmapCount;
    logic overflow;

    // Command lines without comments or blanks
    string cmds[$];
    string testName = "reset";

    // Words still due on outData, oldest first
    peInputPkg::outWord_t expQ[$];

    // Packet kinds tallied from the E lines
    peInputPkg::statCount_t tallyFilter = '0;
    peInputPkg::statCount_t tallyIfmap = '0;

    int cycles = 0;
    int cycleLimit = 0;
    int mismatchErrs = 0;
    int missingErrs = 0;
    int otherErrs = 0;

    peInputTop #(.PE_NODE(4'h5)) i_dut (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .inData      (inData),
        .ack         (ack),
        .outValid    (outValid),
        .outData     (outData),
        .filterCount (filterCount),
        .ifmapCount  (ifmapCount),
        .overflow    (overflow)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Outputs are stable mid cycle
    always @(negedge clk) begin
        if (!rst && outValid) begin
            if (expQ.size() == 0) begin
                $display("Unexpected output %h in test %s", outData, testName);
                otherErrs++;
            end else begin
                checkOut(expQ.pop_front(), outData);
            end
        end
    end

    task automatic checkOut(input peInputPkg::outWord_t expWord,
                            input peInputPkg::outWord_t actWord);
        if (actWord !== expWord) begin
            $display("Mismatch in %s: outData expected %h, actual %h",
                     testName, expWord, actWord);
            mismatchErrs++;
        end
    endtask

    task automatic checkCount(input string what, input peInputPkg::statCount_t expCount,
                              input peInputPkg::statCount_t actCount);
        if (actCount !== expCount) begin
            $display("Mismatch in %s: %s expected %0d, actual %0d",
                     testName, what, expCount, actCount);
            mismatchErrs++;
        end
    endtask

    task automatic checkFlag(input string what, input logic expFlag, input logic actFlag);
        if (actFlag !== expFlag) begin
            $display("Mismatch in %s: %s expected %b, actual %b",
                     testName, what, expFlag, actFlag);
            mismatchErrs++;
        end
    endtask

    // Next drive point, 2 ns after the rising edge
    task automatic advance();
        @(posedge clk);
        #2;
    endtask

    task automatic pushPacket(input peInputPkg::instWord_t pkt);
        inValid = 1'b1;
        inData = pkt;
        advance();
        inValid = 1'b0;
    endtask

    task automatic pulseAck();
        ack = 1'b1;
        advance();
        ack = 1'b0;
    endtask

    // Wait for every queued word, then a few quiet cycles to catch extras
    task automatic drainOutputs();
        while (expQ.size() != 0) begin
            advance();
        end
        repeat (4) advance();
    endtask

    task automatic reportBadLine(input string line);
        $display("Cannot parse stimulus line '%s' in test %s", line, testName);
        otherErrs++;
    endtask

    function automatic string trimLine(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" || r.getc(r.len() - 1) == "\r"
                || r.getc(r.len() - 1) == " ")) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    task automatic finishRun();
        // Anything left in the queue never came out
        while (expQ.size() != 0) begin
            $display("Missing output in %s: %h never appeared", testName, expQ.pop_front());
            missingErrs++;
        end
        $display("Errors: %0d mismatches, %0d missing outputs, %0d other failures",
                 mismatchErrs, missingErrs, otherErrs);
        if (mismatchErrs + missingErrs + otherErrs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic loadCommands();
        int fd;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            otherErrs++;
            finishRun();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    line = trimLine(line);
                    if (line.len() > 0 && line.getc(0) != "#") begin
                        cmds.push_back(line);
                    end
                end
            end
            $fclose(fd);
            // Generous budget per command line
            cycleLimit = 40 * cmds.size();
        end
    endtask

    task automatic runCommand(input string line);
        byte op;
        string arg;
        logic [31:0] val;
        int maxGap;
        int gap;
        int fExp;
        int iExp;
        int oExp;
        op = line.getc(0);
        arg = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
        case (op)
            "T": testName = arg;
            "A": pulseAck();
            "P": begin
                if ($sscanf(arg, "%h", val) != 1) reportBadLine(line);
                else pushPacket(val[13:0]);
            end
            "G": begin
                if ($sscanf(arg, "%d", maxGap) != 1) begin
                    reportBadLine(line);
                end else begin
                    gap = $urandom % (maxGap + 1);
                    repeat (gap) advance();
                end
            end
            "E": begin
                if ($sscanf(arg, "%h", val) != 1) begin
                    reportBadLine(line);
                end else begin
                    expQ.push_back(val[17:0]);
                    // Packet bit 0 lands at bit 4, above the node
                    if (val[4]) tallyFilter = tallyFilter + 1'b1;
                    else tallyIfmap = tallyIfmap + 1'b1;
                end
            end
            "C": begin
                if ($sscanf(arg, "%d %d %d", fExp, iExp, oExp) != 3) begin
                    reportBadLine(line);
                end else begin
                    drainOutputs();
                    checkCount("filterCount", peInputPkg::statCount_t'(fExp), filterCount);
                    checkCount("ifmapCount", peInputPkg::statCount_t'(iExp), ifmapCount);
                    checkFlag("overflow", oExp[0], overflow);
                    if (peInputPkg::statCount_t'(fExp) != tallyFilter
                            || peInputPkg::statCount_t'(iExp) != tallyIfmap) begin
                        $display("Counts on the C line of %s disagree with its E lines",
                                 testName);
                        otherErrs++;
                    end
                end
            end
            default: reportBadLine(line);
        endcase
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inData = '0;
        ack = 1'b0;
        // Seeded once, drives the G gaps
        void'($urandom(38237));
        loadCommands();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (cmds[k]) begin
            runCommand(cmds[k]);
        end
        drainOutputs();
        finishRun();
    end

    // Watchdog
    initial begin
        wait (cycleLimit > 0);
        wait (cycles >= cycleLimit);
        $display("Run timed out after %0d cycles before the stimulus completed", cycles);
        otherErrs++;
        finishRun();
    end

endmodule

// File: tests/peInputTop_tests.txt
# T test name | P packet hex | A ack pulse | G max idle cycles | E expected outData hex
# C expected filterCount, ifmapCount and overflow after draining (cumulative over the run)
T passThrough
E 00015
E 00025
E 1A065
P 0001
G 3
P 0002
G 2
P 1A06
C 1 2 0
T earlyAcks
A
A
E 00085
E 00105
P 0008
P 0010
C 1 4 0
T gatedFill
P 000C
P 0011
P 0021
P 0031
P 0041
P 0051
P 0061
P 0071
P 0081
P 0091
P 00A1
P 00B1
P 00C1
P 00D1
P 00E1
P 00F1
P 3FFF
G 4
A
E 000C5
E 00115
E 00215
E 00315
E 00415
E 00515
E 00615
E 00715
E 00815
E 00915
E 00A15
E 00B15
E 00C15
E 00D15
E 00E15
E 00F15
C 16 5 1
